// File: src/approx_div_pkg.sv
package approx_div_pkg;

  localparam int N_W = 16;           // Dividend width
  localparam int D_W = 8;            // Divisor, quotient and remainder width
  localparam int APPROX_ROWS = 6;    // Low rows built from approximate cells
  localparam int CNT_W = 16;
  localparam int SUM_W = 24;

  // Division request
  typedef struct packed {
    logic [N_W-1:0] n;
    logic [D_W-1:0] d;
  } div_req_t;

  // Approximate and exact results side by side
  typedef struct packed {
    logic [D_W-1:0] q;
    logic [D_W-1:0] r;
    logic [D_W-1:0] q_exact;
    logic [D_W-1:0] r_exact;
    logic           div_zero;   // d == 0
    logic           ovf;        // Quotient does not fit in D_W bits
  } div_res_t;

  // Quotient error statistics
  typedef struct packed {
    logic [CNT_W-1:0] samples;
    logic [CNT_W-1:0] mismatches;
    logic [SUM_W-1:0] err_sum;    // Sum of |q - q_exact|
    logic [D_W-1:0]   err_max;
  } err_stats_t;

endpackage

// File: src/divider_array.sv
module divider_array #(
  parameter int approx_rows = approx_div_pkg::APPROX_ROWS
) (
  input  logic [approx_div_pkg::N_W-1:0] n,
  input  logic [approx_div_pkg::D_W-1:0] d,
  output logic [approx_div_pkg::D_W-1:0] q,
  output logic [approx_div_pkg::D_W-1:0] r
);
  import approx_div_pkg::*;

  // Approximate subtractor cell returning {borrow, difference}
  function automatic logic [1:0] cell_approx(
    input logic x,
    input logic y,
    input logic bin
  );
    logic bout;
    bout = y | (~x & bin);
    return {bout, x};    // Difference is x itself
  endfunction

  // Full subtractor cell
  function automatic logic [1:0] cell_exact(
    input logic x,
    input logic y,
    input logic bin
  );
    logic diff;
    logic bout;
    diff = x ^ y ^ bin;
    bout = (~x & y) | (~(x ^ y) & bin);
    return {bout, diff};
  endfunction

  logic [D_W:0]   part [D_W];   // Partial remainder into each row
  logic [D_W-1:0] rem  [D_W];   // Remainder passed down by each row
  logic [D_W-1:0] qb;

  // Row D_W-1 is the top row and takes the high dividend bits
  // while each lower row shifts in one more dividend bit
  for (genvar i = 0; i < D_W; i++) begin : g_row
    logic [D_W-1:0] dif;
    logic           row_bout;

    if (i == D_W - 1) begin : g_top
      assign part[i] = n[N_W-1:N_W-D_W-1];
    end else begin : g_low
      assign part[i] = {rem[i+1], n[i]};
    end

    // Borrow ripples from cell 0 up to cell D_W-1
    always_comb begin
      logic       b;
      logic [1:0] c;
      b = 1'b0;
      for (int j = 0; j < D_W; j++) begin
        if (i < approx_rows) begin
          c = cell_approx(part[i][j], d[j], b);
        end else begin
          c = cell_exact(part[i][j], d[j], b);
        end
        dif[j] = c[0];
        b      = c[1];
      end
      row_bout = b;
    end

    // Quotient bit from the bit left of the row and the final borrow
    assign qb[i]  = part[i][D_W] | ~row_bout;
    assign rem[i] = qb[i] ? dif : part[i][D_W-1:0];  // Restore on qb low
  end

  assign q = qb;
  assign r = rem[0];

endmodule

// File: src/approx_div_unit.sv
module approx_div_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  approx_div_pkg::div_req_t req,
  output logic                     out_valid,
  output approx_div_pkg::div_res_t res
);
  import approx_div_pkg::*;

  div_req_t       req_q;
  logic           valid_q;
  logic [D_W-1:0] q_apx;
  logic [D_W-1:0] r_apx;
  logic [D_W-1:0] q_ex;
  logic [D_W-1:0] r_ex;
  div_res_t       res_d;

  // Stage 1 request register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
      if (in_valid) begin
        req_q <= req;
      end
    end
  end

  divider_array #(
    .approx_rows(APPROX_ROWS)
  ) u_apx_array (
    .n(req_q.n),
    .d(req_q.d),
    .q(q_apx),
    .r(r_apx)
  );

  // Reference path with all rows exact
  divider_array #(
    .approx_rows(0)
  ) u_exact_array (
    .n(req_q.n),
    .d(req_q.d),
    .q(q_ex),
    .r(r_ex)
  );

  always_comb begin
    res_d.q        = q_apx;
    res_d.r        = r_apx;
    res_d.q_exact  = q_ex;
    res_d.r_exact  = r_ex;
    res_d.div_zero = (req_q.d == '0);
    // High dividend half not below d means quotient needs > D_W bits
    res_d.ovf      = (req_q.n[N_W-1:D_W] >= req_q.d);
  end

  // Stage 2 result register holds while no request is in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res       <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        res <= res_d;
      end
    end
  end

endmodule

// File: src/error_accum.sv
module error_accum (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       out_valid,
  input  approx_div_pkg::div_res_t   res,
  input  logic                       stats_clear,
  output approx_div_pkg::err_stats_t stats
);
  import approx_div_pkg::*;

  logic [D_W-1:0]   abs_diff;
  logic             upd;
  logic [CNT_W-1:0] samples_nxt;
  logic [CNT_W-1:0] mismatches_nxt;
  logic [SUM_W:0]   sum_wide;
  logic [SUM_W-1:0] err_sum_nxt;
  logic [D_W-1:0]   err_max_nxt;

  // Absolute quotient error
  always_comb begin
    if (res.q >= res.q_exact) begin
      abs_diff = res.q - res.q_exact;
    end else begin
      abs_diff = res.q_exact - res.q;
    end
  end

  // Flagged results carry no meaningful quotient
  assign upd = out_valid & ~res.div_zero & ~res.ovf;

  // Saturating counters
  always_comb begin
    if (stats.samples == '1) begin
      samples_nxt = stats.samples;
    end else begin
      samples_nxt = stats.samples + 1'b1;
    end

    mismatches_nxt = stats.mismatches;
    if (abs_diff != '0 && stats.mismatches != '1) begin
      mismatches_nxt = stats.mismatches + 1'b1;
    end

    sum_wide = {1'b0, stats.err_sum} + {{(SUM_W + 1 - D_W){1'b0}}, abs_diff};
    if (sum_wide[SUM_W]) begin
      err_sum_nxt = '1;           // Carry out means overflow
    end else begin
      err_sum_nxt = sum_wide[SUM_W-1:0];
    end

    if (abs_diff > stats.err_max) begin
      err_max_nxt = abs_diff;
    end else begin
      err_max_nxt = stats.err_max;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (stats_clear) begin
      stats <= '0;                // Clear beats a coinciding update
    end else if (upd) begin
      stats.samples    <= samples_nxt;
      stats.mismatches <= mismatches_nxt;
      stats.err_sum    <= err_sum_nxt;
      stats.err_max    <= err_max_nxt;
    end
  end

endmodule

// File: src/approx_div_top.sv
module approx_div_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  approx_div_pkg::div_req_t   req,
  input  logic                       stats_clear,
  output logic                       out_valid,
  output approx_div_pkg::div_res_t   res,
  output approx_div_pkg::err_stats_t stats
);

  // Two stage divider with the result one cycle after the sampling edge
  approx_div_unit u_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .req      (req),
    .out_valid(out_valid),
    .res      (res)
  );

  // Statistics trail the result by one more cycle
  error_accum u_accum (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .res        (res),
    .stats_clear(stats_clear),
    .stats      (stats)
  );

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

// File: testbench/approx_div_props.sv
module approx_div_props (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic out_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  a_reset_low: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

  // Sampled at edge k, visible at edge k+1, seen by the sampler at k+2
  a_follow: assert property (
    @(posedge clk) disable iff (!rst_n) $past(in_valid, 2) |-> out_valid
  ) else $error("out_valid missing one cycle after a sampled in_valid");

  a_no_spurious: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(out_valid) |-> $past(in_valid, 2)
  ) else $error("out_valid rose without a sampled in_valid");

endmodule

bind approx_div_unit approx_div_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .out_valid(out_valid)
);

// File: testbench/approx_div_model.svh
`ifndef APPROX_DIV_MODEL_SVH
`define APPROX_DIV_MODEL_SVH

// Restoring array evaluated bit by bit and returned as {q, r}
// Rows below approx_rows use the approximate cell
function automatic logic [15:0] model_array(
  input logic [15:0] n,
  input logic [7:0]  d,
  input int          approx_rows
);
  logic [8:0] p;
  logic [7:0] dif;
  logic [7:0] rem;
  logic [7:0] q;
  logic       b;
  logic       x;
  logic       y;
  rem = n[15:8];   // Top row sees n[15:7]
  for (int i = 7; i >= 0; i--) begin
    p = {rem, n[i]};
    b = 1'b0;
    for (int j = 0; j < 8; j++) begin
      x = p[j];
      y = d[j];
      if (i < approx_rows) begin
        dif[j] = x;
        b      = y | (~x & b);
      end else begin
        dif[j] = x ^ y ^ b;
        b      = (~x & y) | (~x & b) | (y & b);
      end
    end
    q[i] = p[8] | ~b;
    rem  = q[i] ? dif : p[7:0];
  end
  return {q, rem};
endfunction

function automatic logic [15:0] model_approx(input logic [15:0] n, input logic [7:0] d);
  return model_array(n, d, APPROX_ROWS);
endfunction

// Plain integer division for d nonzero and n[15:8] < d
function automatic logic [15:0] model_exact(input logic [15:0] n, input logic [7:0] d);
  logic [15:0] q;
  logic [15:0] r;
  q = n / {8'd0, d};
  r = n % {8'd0, d};
  return {q[7:0], r[7:0]};
endfunction

`endif

// File: testbench/approx_div_tb.sv
module approx_div_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import approx_div_pkg::*;

  `include "approx_div_model.svh"

  // Rough length of each test in cycles
  localparam int RESET_CYC    = 10;
  localparam int LAT_CYC      = 20;
  localparam int EXACT_CYC    = 210;
  localparam int CORNER_CYC   = 20;
  localparam int FLAG_CYC     = 30;
  localparam int STATS_CYC    = 60;
  localparam int CLEAR_CYC    = 20;
  localparam int WATCHDOG_CYC = 2 * (RESET_CYC + LAT_CYC + EXACT_CYC + CORNER_CYC +
                                     FLAG_CYC + STATS_CYC + CLEAR_CYC);

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  div_req_t   req;
  logic       stats_clear;
  logic       out_valid;
  div_res_t   res;
  err_stats_t stats;

  err_stats_t  exp_stats;   // Running model of the accumulator
  div_req_t    pend[$];     // Requests still to be driven
  logic [31:0] rng;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  tb_clock #(.period_ns(40)) u_clk (.clk(clk));

  approx_div_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .req        (req),
    .stats_clear(stats_clear),
    .out_valid  (out_valid),
    .res        (res),
    .stats      (stats)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at t=%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) value_error(name, 32'(exp), 32'(got));
  endtask

  task automatic check_res(input div_res_t exp, input div_res_t got);
    if (got.q !== exp.q) value_error("res.q", 32'(exp.q), 32'(got.q));
    if (got.r !== exp.r) value_error("res.r", 32'(exp.r), 32'(got.r));
    if (got.q_exact !== exp.q_exact) begin
      value_error("res.q_exact", 32'(exp.q_exact), 32'(got.q_exact));
    end
    if (got.r_exact !== exp.r_exact) begin
      value_error("res.r_exact", 32'(exp.r_exact), 32'(got.r_exact));
    end
    check_bit("res.div_zero", exp.div_zero, got.div_zero);
    check_bit("res.ovf", exp.ovf, got.ovf);
  endtask

  task automatic check_stats(input err_stats_t exp, input err_stats_t got);
    if (got.samples !== exp.samples) begin
      value_error("stats.samples", 32'(exp.samples), 32'(got.samples));
    end
    if (got.mismatches !== exp.mismatches) begin
      value_error("stats.mismatches", 32'(exp.mismatches), 32'(got.mismatches));
    end
    if (got.err_sum !== exp.err_sum) begin
      value_error("stats.err_sum", 32'(exp.err_sum), 32'(got.err_sum));
    end
    if (got.err_max !== exp.err_max) begin
      value_error("stats.err_max", 32'(exp.err_max), 32'(got.err_max));
    end
  endtask

  // Fold one unflagged result into the expected statistics
  task automatic account(input div_res_t e);
    logic [7:0] diff;
    diff = (e.q >= e.q_exact) ? e.q - e.q_exact : e.q_exact - e.q;
    exp_stats.samples = exp_stats.samples + 16'd1;
    if (diff != 8'd0) exp_stats.mismatches = exp_stats.mismatches + 16'd1;
    exp_stats.err_sum = exp_stats.err_sum + {16'd0, diff};
    if (diff > exp_stats.err_max) exp_stats.err_max = diff;
  endtask

  task automatic check_result(input div_req_t rq, input div_res_t got);
    logic        dz;
    logic        ov;
    logic [15:0] a;
    logic [15:0] x;
    div_res_t    e;
    dz = (rq.d == 8'd0);
    ov = (rq.n[15:8] >= rq.d);
    if (dz || ov) begin
      check_bit("res.div_zero", dz, got.div_zero);
      check_bit("res.ovf", ov, got.ovf);
    end else begin
      a          = model_approx(rq.n, rq.d);
      x          = model_exact(rq.n, rq.d);
      e.q        = a[15:8];
      e.r        = a[7:0];
      e.q_exact  = x[15:8];
      e.r_exact  = x[7:0];
      e.div_zero = 1'b0;
      e.ovf      = 1'b0;
      check_res(e, got);
      account(e);
    end
  endtask

  // Random request with d nonzero and no overflow
  task automatic rand_req(output div_req_t r);
    logic [7:0] d;
    rng = xorshift32(rng);
    d   = rng[7:0];
    if (d == 8'd0) d = 8'd1;
    r.d = d;
    r.n = {rng[15:8] % d, rng[23:16]};
  endtask

  // Drive pend back to back and check results in order as they appear
  task automatic run_stream();
    div_req_t sent[$];
    div_req_t rq;
    int       idle;
    idle = 0;
    while (pend.size() > 0 || sent.size() > 0) begin
      @(posedge clk);
      if (pend.size() > 0) begin
        rq = pend.pop_front();
        in_valid <= 1'b1;
        req      <= rq;
        sent.push_back(rq);
      end else begin
        in_valid <= 1'b0;
      end
      @(negedge clk);
      if (out_valid) begin
        idle = 0;
        if (sent.size() == 0) report_error("result arrived with no request in flight");
        else check_result(sent.pop_front(), res);
      end else begin
        idle++;
        if (idle > 8) begin
          report_error("results stopped arriving while requests were in flight");
          sent.delete();
          pend.delete();
        end
      end
    end
  endtask

  // Stats follow the last result by one edge
  task automatic wait_stats();
    @(negedge clk);
    check_stats(exp_stats, stats);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    stats_clear <= 1'b1;
    @(posedge clk);
    stats_clear <= 1'b0;
    exp_stats = '0;
  endtask

  task automatic test_done(input string name, input int start_err);
    if (errors == start_err) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - start_err);
    end
  endtask

  task automatic test_reset_latency();
    int       start_err;
    int       cycles;
    div_req_t rq;
    start_err = errors;
    @(negedge clk);
    check_bit("out_valid", 1'b0, out_valid);
    check_stats(exp_stats, stats);
    rq.n = 16'd1000;
    rq.d = 8'd50;
    @(posedge clk);
    in_valid <= 1'b1;
    req      <= rq;
    @(posedge clk);
    in_valid <= 1'b0;   // DUT samples the request here
    cycles = 0;
    @(negedge clk);
    while (!out_valid && cycles < 8) begin
      cycles++;
      @(negedge clk);
    end
    if (!out_valid) begin
      report_error("out_valid never rose after a single request");
    end else begin
      if (cycles != 1) begin
        report_error($sformatf("out_valid came %0d cycles after sampling, not 1", cycles));
      end
      check_result(rq, res);
      @(negedge clk);
      check_bit("out_valid", 1'b0, out_valid);   // One cycle pulse
      check_stats(exp_stats, stats);
    end
    test_done("reset_latency", start_err);
  endtask

  task automatic test_exact_random();
    int       start_err;
    div_req_t rq;
    start_err = errors;
    for (int k = 0; k < 200; k++) begin
      rand_req(rq);
      pend.push_back(rq);
    end
    run_stream();
    wait_stats();
    test_done("exact_random", start_err);
  endtask

  task automatic test_approx_corners();
    int start_err;
    start_err = errors;
    pend.push_back('{n: 16'h00ab, d: 8'd1});
    pend.push_back('{n: 16'h0000, d: 8'd1});
    pend.push_back('{n: 16'hfeff, d: 8'd255});
    pend.push_back('{n: 16'h00ff, d: 8'd255});
    pend.push_back('{n: 16'h0000, d: 8'd7});
    pend.push_back('{n: {8'd99, 8'hff}, d: 8'd100});
    pend.push_back('{n: {8'd127, 8'h80}, d: 8'd128});
    run_stream();
    wait_stats();
    test_done("approx_corners", start_err);
  endtask

  task automatic test_flags();
    int         start_err;
    div_req_t   rq;
    logic [7:0] hi;
    start_err = errors;
    for (int k = 0; k < 6; k++) begin
      rng  = xorshift32(rng);
      rq.n = rng[15:0];
      rq.d = 8'd0;
      pend.push_back(rq);
      rq.d = rng[23:16] | 8'd1;
      hi   = (rng[31:24] < rq.d) ? rq.d : rng[31:24];   // n[15:8] >= d
      rq.n = {hi, rng[7:0]};
      pend.push_back(rq);
    end
    run_stream();
    wait_stats();   // Flagged results leave stats alone
    test_done("flags", start_err);
  endtask

  task automatic test_stats_stream();
    int       start_err;
    div_req_t rq;
    start_err = errors;
    pulse_clear();
    wait_stats();
    for (int k = 0; k < 40; k++) begin
      rand_req(rq);
      pend.push_back(rq);
    end
    run_stream();
    wait_stats();
    test_done("stats_stream", start_err);
  endtask

  task automatic test_clear();
    int       start_err;
    div_req_t rq;
    start_err = errors;
    pulse_clear();
    wait_stats();
    rand_req(rq);
    @(posedge clk);
    in_valid <= 1'b1;
    req      <= rq;
    @(posedge clk);
    in_valid <= 1'b0;
    @(posedge clk);
    stats_clear <= 1'b1;   // Lands on the edge that would count the result
    @(negedge clk);
    check_bit("out_valid", 1'b1, out_valid);
    check_result(rq, res);
    @(posedge clk);
    stats_clear <= 1'b0;
    exp_stats = '0;
    wait_stats();
    test_done("clear", start_err);
  endtask

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYC);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    req          = '0;
    stats_clear  = 1'b0;
    exp_stats    = '0;
    rng          = 32'd30609;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_latency();
    test_exact_random();
    test_approx_corners();
    test_flags();
    test_stats_stream();
    test_clear();
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: approx_div_top.f
+incdir+testbench
src/approx_div_pkg.sv
src/divider_array.sv
src/approx_div_unit.sv
src/error_accum.sv
src/approx_div_top.sv
testbench/tb_clock.sv
testbench/approx_div_props.sv
testbench/approx_div_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := approx_div_tb
FLIST      := approx_div_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST RESULT: FAIL
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# The log decides the outcome, a crash without a summary also fails
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
